// ==== flist.f ====
hw/rv_pkg.sv
hw/rv_stage_if.sv
hw/rv_fetch.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_core.sv
tests/tb_rv_core.sv

// ==== hw/rv_core.sv ====
module rv_core import rv_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	output logic [xlen-1:0]       imem_addr,
	output logic                  imem_req,
	input  logic [xlen-1:0]       imem_rdata,
	input  logic                  imem_rvalid,
	output logic                  retire_valid,
	output logic [xlen-1:0]       retire_pc,
	output logic                  retire_we,
	output logic [reg_addr_w-1:0] retire_rd,
	output logic [xlen-1:0]       retire_data
);

	logic [reg_addr_w-1:0] rs1_addr;
	logic [reg_addr_w-1:0] rs2_addr;
	logic [xlen-1:0]       rs1_data;
	logic [xlen-1:0]       rs2_data;
	logic                  wr_we;
	logic [reg_addr_w-1:0] wr_addr;
	logic [xlen-1:0]       wr_data;

	fetch_bus fb_if ();
	exec_bus  eb_if ();

	rv_fetch rv_fetch_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.fb          (fb_if.fetch_mp),
		.imem_addr   (imem_addr),
		.imem_req    (imem_req),
		.imem_rdata  (imem_rdata),
		.imem_rvalid (imem_rvalid)
	);

	rv_decode rv_decode_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.fb       (fb_if.decode_mp),
		.eb       (eb_if.decode_mp),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	rv_regfile rv_regfile_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.we       (wr_we),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	rv_execute rv_execute_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.eb           (eb_if.exec_mp),
		.fb           (fb_if.exec_mp),
		.wr_we        (wr_we),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_we    (retire_we),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data)
	);

endmodule

// ==== hw/rv_decode.sv ====
module rv_decode import rv_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	fetch_bus.decode_mp           fb,
	exec_bus.decode_mp            eb,
	output logic [reg_addr_w-1:0] rs1_addr,
	output logic [reg_addr_w-1:0] rs2_addr,
	input  logic [xlen-1:0]       rs1_data,
	input  logic [xlen-1:0]       rs2_data
);

	rv_inst_t        inst;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rs1_val;
	logic [xlen-1:0] rs2_val;
	logic            fwd_rs1;
	logic            fwd_rs2;

	assign inst     = fb.inst;
	assign rs1_addr = inst.r_fmt.rs1;
	assign rs2_addr = inst.r_fmt.rs2;

	// immediate by format
	always_comb begin
		case (inst.r_fmt.opcode)
			op_lui, op_auipc: begin
				imm = {inst.u_fmt.imm_31_12, 12'b0};
			end
			op_jal: begin
				imm = {
					{(xlen-20){inst.j_fmt.imm_20}},
					inst.j_fmt.imm_19_12,
					inst.j_fmt.imm_11,
					inst.j_fmt.imm_10_1,
					1'b0
				};
			end
			op_branch: begin
				imm = {
					{(xlen-12){inst.b_fmt.imm_12}},
					inst.b_fmt.imm_11,
					inst.b_fmt.imm_10_5,
					inst.b_fmt.imm_4_1,
					1'b0
				};
			end
			op_reg: begin
				imm = '0;
			end
			// jalr, op_imm and anything unknown
			default: begin
				imm = {{(xlen-12){inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
			end
		endcase
	end

	// execute result beats the register file
	assign fwd_rs1 = eb.fwd_we && (eb.fwd_rd == rs1_addr);
	assign fwd_rs2 = eb.fwd_we && (eb.fwd_rd == rs2_addr);
	assign rs1_val = fwd_rs1 ? eb.fwd_data : rs1_data;
	assign rs2_val = fwd_rs2 ? eb.fwd_data : rs2_data;

	// a redirect squashes whatever sits in the buffer
	always_ff @(posedge clk) begin
		if (!rst_n || fb.redirect) begin
			eb.valid <= 1'b0;
		end else begin
			eb.valid <= fb.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (fb.valid) begin
			eb.pc      <= fb.pc;
			eb.inst    <= inst;
			eb.imm     <= imm;
			eb.rs1_val <= rs1_val;
			eb.rs2_val <= rs2_val;
		end
	end

	// forwarding never checks for x0, so execute must not offer it
	a_no_x0_forward: assert property (
		@(posedge clk) disable iff (!rst_n)
		eb.fwd_we |-> eb.fwd_rd != '0
	);

endmodule

// ==== hw/rv_execute.sv ====
module rv_execute import rv_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	exec_bus.exec_mp              eb,
	fetch_bus.exec_mp             fb,
	output logic                  wr_we,
	output logic [reg_addr_w-1:0] wr_addr,
	output logic [xlen-1:0]       wr_data,
	output logic                  retire_valid,
	output logic [xlen-1:0]       retire_pc,
	output logic                  retire_we,
	output logic [reg_addr_w-1:0] retire_rd,
	output logic [xlen-1:0]       retire_data
);

	rv_inst_t              inst;
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [reg_addr_w-1:0] rd;
	logic [2:0]            alu_f3;
	logic                  alt_op;
	logic [xlen-1:0]       alu_a;
	logic [xlen-1:0]       alu_b;
	logic [xlen-1:0]       alu_out;
	logic [xlen-1:0]       result;
	logic                  is_jump;
	logic                  writes_rd;
	logic                  taken;
	logic                  rs_lt;
	logic                  rs_ltu;

	assign inst   = eb.inst;
	assign opcode = inst.r_fmt.opcode;
	assign funct3 = inst.r_fmt.funct3;
	assign rd     = inst.r_fmt.rd;

	// lui adds to zero, auipc to pc
	assign alu_a = (opcode == op_auipc) ? eb.pc :
	               (opcode == op_lui)   ? '0    : eb.rs1_val;
	assign alu_b = (opcode == op_reg) ? eb.rs2_val : eb.imm;

	assign alu_f3 = (opcode == op_reg || opcode == op_imm) ? funct3 : f3_add;
	// sub for register ops, sra for both shift forms
	assign alt_op = inst.r_fmt.funct7[5] &&
	                (opcode == op_reg || (opcode == op_imm && funct3 == f3_sr));

	always_comb begin
		case (alu_f3)
			f3_add:  alu_out = (alt_op && opcode == op_reg) ? alu_a - alu_b : alu_a + alu_b;
			f3_sll:  alu_out = alu_a << alu_b[4:0];
			f3_slt:  alu_out = xlen'($signed(alu_a) < $signed(alu_b));
			f3_sltu: alu_out = xlen'(alu_a < alu_b);
			f3_xor:  alu_out = alu_a ^ alu_b;
			f3_sr:   alu_out = alt_op ? $unsigned($signed(alu_a) >>> alu_b[4:0])
			                          : alu_a >> alu_b[4:0];
			f3_or:   alu_out = alu_a | alu_b;
			default: alu_out = alu_a & alu_b;
		endcase
	end

	// branch compare
	assign rs_lt  = $signed(eb.rs1_val) < $signed(eb.rs2_val);
	assign rs_ltu = eb.rs1_val < eb.rs2_val;

	always_comb begin
		case (inst.b_fmt.funct3)
			f3_beq:  taken = eb.rs1_val == eb.rs2_val;
			f3_bne:  taken = eb.rs1_val != eb.rs2_val;
			f3_blt:  taken = rs_lt;
			f3_bge:  taken = !rs_lt;
			f3_bltu: taken = rs_ltu;
			f3_bgeu: taken = !rs_ltu;
			default: taken = 1'b0;
		endcase
	end

	assign is_jump   = (opcode == op_jal) || (opcode == op_jalr);
	assign writes_rd = is_jump || opcode == op_lui || opcode == op_auipc ||
	                   opcode == op_imm || opcode == op_reg;
	assign result    = is_jump ? eb.pc + xlen'(4) : alu_out;

	assign fb.redirect = eb.valid && (is_jump || (opcode == op_branch && taken));
	assign fb.target   = (opcode == op_jalr) ? ((eb.rs1_val + eb.imm) & ~xlen'(1))
	                                         : eb.pc + eb.imm;

	// x0 never counts as written
	assign eb.fwd_we   = eb.valid && writes_rd && rd != '0;
	assign eb.fwd_rd   = rd;
	assign eb.fwd_data = result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
			retire_we    <= 1'b0;
		end else begin
			retire_valid <= eb.valid;
			retire_we    <= eb.fwd_we;
		end
	end

	// rd and data read zero on a retire without a write
	always_ff @(posedge clk) begin
		retire_pc   <= eb.pc;
		retire_rd   <= eb.fwd_we ? rd : '0;
		retire_data <= eb.fwd_we ? result : '0;
	end

	// the retire record doubles as the register write
	assign wr_we   = retire_we;
	assign wr_addr = retire_rd;
	assign wr_data = retire_data;

endmodule

// ==== hw/rv_fetch.sv ====
module rv_fetch import rv_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	fetch_bus.fetch_mp      fb,
	output logic [xlen-1:0] imem_addr,
	output logic            imem_req,
	input  logic [xlen-1:0] imem_rdata,
	input  logic            imem_rvalid
);

	logic [xlen-1:0] pc;
	logic [xlen-1:0] req_pc;
	logic            pend;

	// redirect steers this cycle's request straight to the target
	assign imem_addr = fb.redirect ? fb.target : pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			imem_req <= 1'b0;
			pend     <= 1'b0;
			pc       <= reset_pc;
		end else begin
			imem_req <= 1'b1;
			pend     <= imem_req;
			if (imem_req) begin
				pc <= imem_addr + xlen'(4);
			end
		end
	end

	// pc of the request in flight
	always_ff @(posedge clk) begin
		if (imem_req) begin
			req_pc <= imem_addr;
		end
	end

	// returning word belongs to the old path when a redirect is up
	assign fb.valid = pend && imem_rvalid && !fb.redirect;
	assign fb.pc    = req_pc;
	assign fb.inst  = imem_rdata;

	// jump targets come from execute; misaligned ones are not trapped
	a_target_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		fb.redirect |-> (fb.target[1:0] == 2'b00)
	);

endmodule

// ==== hw/rv_pkg.sv ====
package rv_pkg;

	// machine word and register index widths
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;

	localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

	// major opcodes handled by the core
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;

	// alu funct3
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// branch funct3
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// one instruction word, five ways to slice it
	typedef union packed {
		struct packed {
			logic [6:0]            funct7;
			logic [reg_addr_w-1:0] rs2;
			logic [reg_addr_w-1:0] rs1;
			logic [2:0]            funct3;
			logic [reg_addr_w-1:0] rd;
			logic [6:0]            opcode;
		} r_fmt;
		struct packed {
			logic [11:0]           imm_11_0;
			logic [reg_addr_w-1:0] rs1;
			logic [2:0]            funct3;
			logic [reg_addr_w-1:0] rd;
			logic [6:0]            opcode;
		} i_fmt;
		// branch offset bits are scattered around rs1/rs2
		struct packed {
			logic                  imm_12;
			logic [5:0]            imm_10_5;
			logic [reg_addr_w-1:0] rs2;
			logic [reg_addr_w-1:0] rs1;
			logic [2:0]            funct3;
			logic [3:0]            imm_4_1;
			logic                  imm_11;
			logic [6:0]            opcode;
		} b_fmt;
		struct packed {
			logic [19:0]           imm_31_12;
			logic [reg_addr_w-1:0] rd;
			logic [6:0]            opcode;
		} u_fmt;
		struct packed {
			logic                  imm_20;
			logic [9:0]            imm_10_1;
			logic                  imm_11;
			logic [7:0]            imm_19_12;
			logic [reg_addr_w-1:0] rd;
			logic [6:0]            opcode;
		} j_fmt;
	} rv_inst_t;

endpackage

// ==== hw/rv_regfile.sv ====
module rv_regfile import rv_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [reg_addr_w-1:0] rs1_addr,
	input  logic [reg_addr_w-1:0] rs2_addr,
	output logic [xlen-1:0]       rs1_data,
	output logic [xlen-1:0]       rs2_data,
	input  logic                  we,
	input  logic [reg_addr_w-1:0] wr_addr,
	input  logic [xlen-1:0]       wr_data
);

	// x0 has no storage
	logic [xlen-1:0] regs [31:1];

	always_ff @(posedge clk) begin
		if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// write-through so a same-cycle reader sees the new value
	always_comb begin
		if (rs1_addr == '0) begin
			rs1_data = '0;
		end else if (we && wr_addr == rs1_addr) begin
			rs1_data = wr_data;
		end else begin
			rs1_data = regs[rs1_addr];
		end
		if (rs2_addr == '0) begin
			rs2_data = '0;
		end else if (we && wr_addr == rs2_addr) begin
			rs2_data = wr_data;
		end else begin
			rs2_data = regs[rs2_addr];
		end
	end

	// execute reports writes to x0 with the enable low
	a_no_x0_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		we |-> wr_addr != '0
	);

endmodule

// ==== hw/rv_stage_if.sv ====
// fetch to decode, plus the redirect from execute
interface fetch_bus import rv_pkg::*; ();
	logic            valid;
	logic [xlen-1:0] pc;
	rv_inst_t        inst;
	logic            redirect;
	logic [xlen-1:0] target;

	modport fetch_mp (output valid, pc, inst, input redirect, target);
	modport decode_mp (input valid, pc, inst, redirect);
	modport exec_mp (output redirect, target);
endinterface

// decode buffer to execute, forwarding path back
interface exec_bus import rv_pkg::*; ();
	logic                  valid;
	logic [xlen-1:0]       pc;
	rv_inst_t              inst;
	logic [xlen-1:0]       imm;
	logic [xlen-1:0]       rs1_val;
	logic [xlen-1:0]       rs2_val;
	logic                  fwd_we;
	logic [reg_addr_w-1:0] fwd_rd;
	logic [xlen-1:0]       fwd_data;

	modport decode_mp (
		output valid, pc, inst, imm, rs1_val, rs2_val,
		input  fwd_we, fwd_rd, fwd_data
	);
	modport exec_mp (
		input  valid, pc, inst, imm, rs1_val, rs2_val,
		output fwd_we, fwd_rd, fwd_data
	);
endinterface

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_rv_core -f flist.f -o tb_rv_core_sim
out=$(./obj_dir/tb_rv_core_sim) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "^Test OK$"; then
	exit 0
fi
exit 1

// ==== tests/rv_testdata.txt ====
# P <addr> <word> : program word at a byte address
# R <pc> <we> <rd> <data> : expected retire record, in program order
P 80000000 123450b7
P 80000004 67808093
P 80000008 ffb00113
P 8000000c 001121b3
P 80000010 00113233
P 80000014 402082b3
P 80000018 40115313
P 8000001c 01c15393
P 80000020 00309433
P 80000024 001444b3
P 80000028 00001517
P 8000002c 00108013
P 80000030 0020c463
P 80000034 0020e663
P 80000038 00100593
P 80000040 00c0066f
P 80000044 00300693
P 8000004c 00000717
P 80000050 010707e7
P 80000054 00400693
P 8000005c 00100833
P 80000060 0f087893
P 80000064 fff13913
P 80000068 00317463
P 8000006c 00600693
P 80000070 0000006f
R 80000000 1 01 12345000
R 80000004 1 01 12345678
R 80000008 1 02 fffffffb
R 8000000c 1 03 00000001
R 80000010 1 04 00000000
R 80000014 1 05 1234567d
R 80000018 1 06 fffffffd
R 8000001c 1 07 0000000f
R 80000020 1 08 2468acf0
R 80000024 1 09 365cfa88
R 80000028 1 0a 80001028
R 8000002c 0 00 00000000
R 80000030 0 00 00000000
R 80000034 0 00 00000000
R 80000040 1 0c 80000044
R 8000004c 1 0e 8000004c
R 80000050 1 0f 80000054
R 8000005c 1 10 12345678
R 80000060 1 11 00000070
R 80000064 1 12 00000001
R 80000068 0 00 00000000
R 80000070 0 00 00000000

// ==== tests/tb_rv_core.sv ====
module tb_rv_core import rv_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [xlen-1:0] nop_word    = 32'h0000_0013;
	localparam int              loop_checks = 4;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic [xlen-1:0]       imem_addr;
	logic                  imem_req;
	logic [xlen-1:0]       imem_rdata;
	logic                  imem_rvalid;
	logic                  retire_valid;
	logic [xlen-1:0]       retire_pc;
	logic                  retire_we;
	logic [reg_addr_w-1:0] retire_rd;
	logic [xlen-1:0]       retire_data;

	logic [xlen-1:0]       imem [logic [xlen-1:0]];
	logic [xlen-1:0]       exp_pc_q[$];
	bit                    exp_we_q[$];
	logic [reg_addr_w-1:0] exp_rd_q[$];
	logic [xlen-1:0]       exp_data_q[$];
	int                    loop_retires = 0;
	int                    cycle_count  = 0;
	int                    cycle_limit  = 0;
	bit                    first_req_seen = 1'b0;

	rv_core rv_core_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.imem_addr    (imem_addr),
		.imem_req     (imem_req),
		.imem_rdata   (imem_rdata),
		.imem_rvalid  (imem_rvalid),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_we    (retire_we),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data)
	);

	always #50 clk = ~clk;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_fetch_addr(
		input logic [xlen-1:0] exp_addr,
		input logic [xlen-1:0] got_addr
	);
		if (got_addr !== exp_addr) begin
			stop_with_error($sformatf("MISMATCH at time %0t: imem_addr expected %h got %h",
				$time, exp_addr, got_addr));
		end
	endtask

	task automatic check_retire(
		input logic [xlen-1:0]       exp_pc,
		input bit                    exp_we,
		input logic [reg_addr_w-1:0] exp_rd,
		input logic [xlen-1:0]       exp_data
	);
		if (retire_pc !== exp_pc) begin
			stop_with_error($sformatf("MISMATCH at time %0t: retire_pc expected %h got %h",
				$time, exp_pc, retire_pc));
		end else if (retire_we !== exp_we) begin
			stop_with_error($sformatf("MISMATCH at time %0t: retire_we expected %h got %h",
				$time, exp_we, retire_we));
		end else if (retire_rd !== exp_rd) begin
			stop_with_error($sformatf("MISMATCH at time %0t: retire_rd expected %h got %h",
				$time, exp_rd, retire_rd));
		end else if (retire_data !== exp_data) begin
			stop_with_error($sformatf("MISMATCH at time %0t: retire_data expected %h got %h",
				$time, exp_data, retire_data));
		end
	endtask

	// P lines fill the memory, R lines the expected trace
	task automatic load_testdata();
		int              fd;
		int              c;
		int              n;
		logic [7:0]      ch;
		logic [xlen-1:0] rec_addr;
		logic [xlen-1:0] rec_word;
		logic            rec_we;
		logic [reg_addr_w-1:0] rec_rd;

		fd = $fopen("tests/rv_testdata.txt", "r");
		if (fd == 0) begin
			stop_with_error("could not open the test data file tests/rv_testdata.txt");
		end
		c = $fgetc(fd);
		while (c != -1) begin
			ch = c[7:0];
			if (ch == "P") begin
				n = $fscanf(fd, "%h %h", rec_addr, rec_word);
				if (n != 2) begin
					stop_with_error("a program line in the test data file is malformed");
				end
				imem[rec_addr] = rec_word;
			end else if (ch == "R") begin
				n = $fscanf(fd, "%h %h %h %h", rec_addr, rec_we, rec_rd, rec_word);
				if (n != 4) begin
					stop_with_error("a retire line in the test data file is malformed");
				end
				exp_pc_q.push_back(rec_addr);
				exp_we_q.push_back(rec_we);
				exp_rd_q.push_back(rec_rd);
				exp_data_q.push_back(rec_word);
			end else if (ch == "#") begin
				while (c != -1 && c[7:0] != "\n") begin
					c = $fgetc(fd);
				end
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
		if (exp_pc_q.size() == 0) begin
			stop_with_error("the test data file holds no expected retire records");
		end
	endtask

	// memory answers in the cycle after the request
	always @(posedge clk) begin : imem_model
		logic [xlen-1:0] addr_s;
		logic            req_s;

		addr_s = imem_addr;
		req_s  = imem_req;
		if (req_s === 1'b1 && !first_req_seen) begin
			first_req_seen = 1'b1;
			check_fetch_addr(reset_pc, addr_s);
		end
		#1;
		imem_rvalid = (req_s === 1'b1);
		if (req_s === 1'b1 && imem.exists(addr_s)) begin
			imem_rdata = imem[addr_s];
		end else begin
			imem_rdata = nop_word;
		end
	end

	// last record is the self-loop and keeps matching
	always @(negedge clk) begin
		if (!rst_n) begin
			if (retire_valid !== 1'b0) begin
				stop_with_error("a retire strobe was seen while reset was held");
			end
			if (imem_req !== 1'b0) begin
				stop_with_error("a memory request was seen while reset was held");
			end
		end else if (retire_valid === 1'b1) begin
			check_retire(exp_pc_q[0], exp_we_q[0], exp_rd_q[0], exp_data_q[0]);
			if (exp_pc_q.size() > 1) begin
				void'(exp_pc_q.pop_front());
				void'(exp_we_q.pop_front());
				void'(exp_rd_q.pop_front());
				void'(exp_data_q.pop_front());
			end else begin
				loop_retires = loop_retires + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			stop_with_error($sformatf("timeout after %0d cycles, the retire trace did not complete",
				cycle_count));
		end
	end

	initial begin
		rst_n       = 1'b0;
		imem_rdata  = nop_word;
		imem_rvalid = 1'b0;
		load_testdata();
		cycle_limit = exp_pc_q.size() * 4 + 100;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		wait (loop_retires == loop_checks);
		$display("Test OK");
		$finish;
	end

endmodule
